//--- verilog.f
+incdir+rtl
rtl/agcPkg.sv
rtl/magEstimator.sv
rtl/log2Converter.sv
rtl/agcLoopFilter.sv
rtl/agcRegs.sv
rtl/channelAgc.sv
bench/agcChecker.sv
bench/tbChannelAgc.sv

//--- Makefile
TOP = tbChannelAgc

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for a pass"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal --top-module $(TOP) -f verilog.f --Mdir obj_dir -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- bench/tbChannelAgc.sv
/*
 * Testbench for the two-channel AGC
 * Clock, reset, sample streams, register accesses and the test sequence
 */
`include "agc_config.svh"

module tbChannelAgc;

    logic                       clk;
    logic                       rst;
    logic                       sampleValid;
    agcPkg::DualIq              sample;
    logic                       regWr;
    logic                       regRd;
    logic [`AGC_ADDR_WIDTH-1:0] regAddr;
    logic [31:0]                regWrData;
    logic [31:0]                regRdData;
    logic                       gainValid;
    agcPkg::GainPair            gains;
    agcPkg::GainPair            modelGains;
    int                         chkErrors;
    int                         chkCount;
    int                         chkPending;
    int                         ownErrors;
    int                         ownChecks;
    int                         errorsBefore;

    channelAgc u_dut (
        .clk(clk), .rst(rst), .sampleValid(sampleValid), .sample(sample),
        .regWr(regWr), .regRd(regRd), .regAddr(regAddr), .regWrData(regWrData),
        .regRdData(regRdData), .gainValid(gainValid), .gains(gains)
    );

    // Model of the level paths and loop, watching the DUT ports
    agcChecker u_check (
        .clk(clk), .rst(rst), .sampleValid(sampleValid), .sample(sample),
        .regWr(regWr), .regRd(regRd), .regAddr(regAddr), .regWrData(regWrData),
        .regRdData(regRdData), .gainValid(gainValid), .gains(gains),
        .errors(chkErrors), .checks(chkCount), .pending(chkPending),
        .shownGains(modelGains)
    );

    always #5 clk = ~clk;

    // Inputs change 1 unit after the rising edge
    task automatic waitDriveSlot();
        @(posedge clk);
        #1;
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // Mostly random with the full-scale corners mixed in
    function automatic logic [`AGC_SAMPLE_WIDTH-1:0] randomComponent();
        int pick;
        pick = int'($urandom_range(7));
        case (pick)
            0:       return 18'h1FFFF;
            1:       return 18'h20001;
            2:       return 18'h20000;
            default: return 18'($urandom);
        endcase
    endfunction

    task automatic sendSamples(int count, int maxGap, bit useFixed,
                               logic [`AGC_SAMPLE_WIDTH-1:0] fixedVal);
        int gap;
        for (int n = 0; n < count; n++) begin
            waitDriveSlot();
            sampleValid = 1'b1;
            if (useFixed) begin
                sample = {fixedVal, fixedVal, fixedVal, fixedVal};
            end else begin
                sample.ch0.i = randomComponent();
                sample.ch0.q = randomComponent();
                sample.ch1.i = randomComponent();
                sample.ch1.q = randomComponent();
            end
            // Idle cycles between samples
            gap = (maxGap > 0) ? int'($urandom_range(maxGap)) : 0;
            repeat (gap) begin
                waitDriveSlot();
                sampleValid = 1'b0;
            end
        end
        waitDriveSlot();
        sampleValid = 1'b0;
    endtask

    task automatic writeReg(logic [`AGC_ADDR_WIDTH-1:0] addr, logic [31:0] data);
        waitDriveSlot();
        regWr     = 1'b1;
        regAddr   = addr;
        regWrData = data;
        waitDriveSlot();
        regWr = 1'b0;
    endtask

    // Read data is registered, so it is there one edge after the strobe
    task automatic readReg(logic [`AGC_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        waitDriveSlot();
        regRd   = 1'b1;
        regAddr = addr;
        waitDriveSlot();
        regRd = 1'b0;
        data  = regRdData;
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (chkPending != 0 && n < 100) begin
            waitDriveSlot();
            n++;
        end
        if (chkPending != 0) begin
            abortRun("Timeout: gain pairs still in flight after 100 cycles");
        end
    endtask

    task automatic checkValue(string what, logic [31:0] got, logic [31:0] expected);
        ownChecks++;
        if (got !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
            ownErrors++;
        end
    endtask

    task automatic finishTest(string name);
        int now;
        now = chkErrors + ownErrors;
        $display("Test %s: %s, %0d errors", name, (now == errorsBefore) ? "ok" : "errors",
                 now - errorsBefore);
        errorsBefore = now;
    endtask

    initial begin
        agcPkg::GainPair held;
        logic [31:0]     rd;
        void'($urandom(32'haf14));
        clk = 1'b0;
        rst = 1'b1;
        sampleValid = 1'b0;
        sample = '0;
        regWr = 1'b0;
        regRd = 1'b0;
        regAddr = '0;
        regWrData = '0;
        ownErrors = 0;
        ownChecks = 0;
        errorsBefore = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // No gains before a sample and registers at their reset values
        repeat (20) waitDriveSlot();
        readReg(`AGC_REG_CTRL, rd);
        checkValue("CTRL after reset", rd, 32'd0);
        readReg(`AGC_REG_SETPOINT, rd);
        checkValue("SETPOINT after reset", rd, 32'(`AGC_SETPOINT_RESET));
        readReg(`AGC_REG_SHIFT, rd);
        checkValue("SHIFT after reset", rd, 32'(`AGC_SHIFT_RESET));
        sendSamples(1, 0, 1'b1, '0);
        waitDrain();
        // Positive error from 2^31 clamps at the top
        checkValue("first gain0", 32'(gains.gain0), 32'h000F_FFFF);
        checkValue("first gain1", 32'(gains.gain1), 32'h000F_FFFF);
        finishTest("reset state");

        sendSamples(200, 0, 1'b0, '0);
        sendSamples(200, 3, 1'b0, '0);
        waitDrain();
        finishTest("random streams");

        // Retune while samples are still in flight
        sendSamples(20, 0, 1'b0, '0);
        writeReg(`AGC_REG_SETPOINT, 32'h600);
        writeReg(`AGC_REG_SHIFT, 32'd9);
        sendSamples(100, 2, 1'b0, '0);
        writeReg(`AGC_REG_SETPOINT, 32'h100);
        writeReg(`AGC_REG_SHIFT, 32'd15);
        // Full-scale input sits far above the setpoint
        sendSamples(60, 0, 1'b1, 18'h1FFFF);
        waitDrain();
        checkValue("gain0 at low clamp", 32'(gains.gain0), 32'd0);
        checkValue("gain1 at low clamp", 32'(gains.gain1), 32'd0);
        writeReg(`AGC_REG_SETPOINT, 32'hFFF);
        sendSamples(40, 0, 1'b1, '0);
        waitDrain();
        checkValue("gain0 at high clamp", 32'(gains.gain0), 32'h000F_FFFF);
        checkValue("gain1 at high clamp", 32'(gains.gain1), 32'h000F_FFFF);
        finishTest("loop retuning");

        writeReg(`AGC_REG_SETPOINT, 32'h900);
        writeReg(`AGC_REG_SHIFT, 32'd6);
        sendSamples(30, 0, 1'b0, '0);
        waitDrain();
        // Model gains just before the loop stops
        held = modelGains;
        writeReg(`AGC_REG_CTRL, 32'd2);
        sendSamples(50, 2, 1'b0, '0);
        waitDrain();
        checkValue("frozen gain0", 32'(gains.gain0), 32'(held.gain0));
        checkValue("frozen gain1", 32'(gains.gain1), 32'(held.gain1));
        writeReg(`AGC_REG_CTRL, 32'd0);
        sendSamples(30, 1, 1'b0, '0);
        waitDrain();
        finishTest("freeze");

        writeReg(`AGC_REG_CTRL, 32'd1);
        sendSamples(30, 1, 1'b0, '0);
        waitDrain();
        checkValue("bypass gain0", 32'(gains.gain0), 32'(`AGC_UNITY_GAIN));
        checkValue("bypass gain1", 32'(gains.gain1), 32'(`AGC_UNITY_GAIN));
        writeReg(`AGC_REG_CTRL, 32'd0);
        sendSamples(30, 1, 1'b0, '0);
        waitDrain();
        finishTest("bypass");

        // Level and gain reads are compared by the checker
        sendSamples(1, 0, 1'b0, '0);
        waitDrain();
        readReg(`AGC_REG_LEVEL0, rd);
        readReg(`AGC_REG_LEVEL1, rd);
        readReg(`AGC_REG_GAIN0, rd);
        writeReg(`AGC_REG_GAIN1, 32'h0);
        readReg(`AGC_REG_GAIN1, rd);
        readReg(4'd7, rd);
        checkValue("unused address 7", rd, 32'd0);
        readReg(4'd15, rd);
        checkValue("unused address 15", rd, 32'd0);
        waitDrain();
        finishTest("readback");

        $display("Checks: %0d, errors: %0d", chkCount + ownChecks, chkErrors + ownErrors);
        if (chkErrors + ownErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/agcChecker.sv
/*
 * AGC checker
 * Reference model of the level paths and gain loop that compares gains and register reads
 */
`include "agc_config.svh"

module agcChecker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sampleValid,
    input  agcPkg::DualIq              sample,
    input  logic                       regWr,
    input  logic                       regRd,
    input  logic [`AGC_ADDR_WIDTH-1:0] regAddr,
    input  logic [31:0]                regWrData,
    input  logic [31:0]                regRdData,
    input  logic                       gainValid,
    input  agcPkg::GainPair            gains,
    output int                         errors,
    output int                         checks,
    output int                         pending,
    output agcPkg::GainPair            shownGains
);

    localparam longint AccMax = (longint'(1) << 31) - 1;

    agcPkg::LevelPair levelQ[$];
    int               levelDue[$];
    agcPkg::GainPair  gainQ[$];
    int               gainDue[$];
    agcPkg::AgcCtrl   mirror;
    agcPkg::LevelPair latestLevels;
    agcPkg::LevelPair lv;
    agcPkg::GainPair  expGains;
    longint           acc0;
    longint           acc1;
    int               cycle;
    int               due;
    logic             rdPending;
    logic [31:0]      rdExpect;

    // alpha*max + beta*min on saturated magnitudes
    function automatic int estimateMagnitude(agcPkg::IqSample s);
        longint a;
        longint b;
        longint hi;
        longint lo;
        longint sum;
        a = longint'($signed(s.i));
        b = longint'($signed(s.q));
        a = (a < 0) ? -a : a;
        b = (b < 0) ? -b : b;
        // Only -2^17 exceeds full scale
        a = (a > 131071) ? 131071 : a;
        b = (b > 131071) ? 131071 : b;
        hi = (a > b) ? a : b;
        lo = (a > b) ? b : a;
        sum = ((hi * `AGC_ALPHA) >> 17) + ((lo * `AGC_BETA) >> 17);
        return int'((sum > 65535) ? 65535 : sum);
    endfunction

    // Piecewise-linear log2 in 4.8 format
    function automatic logic [`AGC_LOG_WIDTH-1:0] linearToLog(int x);
        int         lead;
        int         src;
        logic [7:0] frac;
        lead = 0;
        frac = '0;
        for (int b = 0; b < 16; b++) begin
            if (x[b]) begin
                lead = b;
            end
        end
        // Bits just under the leading one fill the fraction and zeros follow past bit 0
        for (int j = 0; j < 8; j++) begin
            src = lead - 1 - j;
            frac[7 - j] = (src >= 0) ? x[src] : 1'b0;
        end
        return (x == 0) ? '0 : {4'(lead), frac};
    endfunction

    // One integrator update that holds while frozen or bypassed
    function automatic longint integrateStep(longint acc, int level, agcPkg::AgcCtrl c);
        longint next;
        if (c.freeze || c.bypass) begin
            return acc;
        end
        next = acc + (longint'(c.setpoint) - level) * (longint'(1) << c.loopShift);
        return (next < 0) ? 0 : ((next > AccMax) ? AccMax : next);
    endfunction

    // Gain is the accumulator's upper bits unless bypassed
    function automatic logic [`AGC_GAIN_WIDTH-1:0] gainFromAcc(longint acc, logic bypass);
        return bypass ? `AGC_UNITY_GAIN : `AGC_GAIN_WIDTH'(acc >> 11);
    endfunction

    // Register map as seen by software
    function automatic logic [31:0] expectedRead(logic [`AGC_ADDR_WIDTH-1:0] addr);
        case (addr)
            `AGC_REG_CTRL:     return {30'd0, mirror.freeze, mirror.bypass};
            `AGC_REG_SETPOINT: return 32'(mirror.setpoint);
            `AGC_REG_SHIFT:    return 32'(mirror.loopShift);
            `AGC_REG_LEVEL0:   return 32'(latestLevels.level0);
            `AGC_REG_LEVEL1:   return 32'(latestLevels.level1);
            `AGC_REG_GAIN0:    return 32'(shownGains.gain0);
            `AGC_REG_GAIN1:    return 32'(shownGains.gain1);
            default:           return 32'd0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            levelQ.delete();
            levelDue.delete();
            gainQ.delete();
            gainDue.delete();
            mirror.bypass    = 1'b0;
            mirror.freeze    = 1'b0;
            mirror.setpoint  = `AGC_SETPOINT_RESET;
            mirror.loopShift = `AGC_SHIFT_RESET;
            acc0             = longint'(`AGC_INIT_ACC);
            acc1             = longint'(`AGC_INIT_ACC);
            shownGains.gain0 = `AGC_GAIN_WIDTH'(acc0 >> 11);
            shownGains.gain1 = `AGC_GAIN_WIDTH'(acc1 >> 11);
            latestLevels     = '0;
            rdPending        = 1'b0;
            cycle            = 0;
        end else begin
            cycle++;
            // Gain pairs fall due 5 cycles after their sample
            if (gainValid) begin
                if (gainQ.size() == 0) begin
                    $display("Error at %0t: gainValid high with no sample in flight", $time);
                    errors++;
                end else begin
                    expGains = gainQ.pop_front();
                    due = gainDue.pop_front();
                    checks++;
                    if (due != cycle) begin
                        $display("Error at %0t: gain pair came %0d cycles after its sample",
                                 $time, cycle - due + 5);
                        errors++;
                    end
                    if (gains !== expGains) begin
                        $display("FAILED at %0t: gains %h/%h, expected %h/%h", $time,
                                 gains.gain0, gains.gain1, expGains.gain0, expGains.gain1);
                        errors++;
                    end
                    shownGains = expGains;
                end
            end else if (gainDue.size() > 0 && gainDue[0] <= cycle) begin
                $display("Error at %0t: gainValid did not arrive for an accepted sample", $time);
                errors++;
                void'(gainQ.pop_front());
                void'(gainDue.pop_front());
            end
            // Pair reaching the loop filter at this edge sees the old control
            if (levelDue.size() > 0 && levelDue[0] == cycle) begin
                lv = levelQ.pop_front();
                void'(levelDue.pop_front());
                latestLevels = lv;
                acc0 = integrateStep(acc0, int'(lv.level0), mirror);
                acc1 = integrateStep(acc1, int'(lv.level1), mirror);
                expGains.gain0 = gainFromAcc(acc0, mirror.bypass);
                expGains.gain1 = gainFromAcc(acc1, mirror.bypass);
                gainQ.push_back(expGains);
                gainDue.push_back(cycle + 1);
            end
            // Read data of last cycle's strobe
            if (rdPending) begin
                checks++;
                if (regRdData !== rdExpect) begin
                    $display("FAILED at %0t: read data %h, expected %h", $time,
                             regRdData, rdExpect);
                    errors++;
                end
            end
            rdPending = regRd;
            if (regRd) begin
                rdExpect = expectedRead(regAddr);
            end
            // Four cycles through both level stages
            if (sampleValid) begin
                lv.level0 = linearToLog(estimateMagnitude(sample.ch0));
                lv.level1 = linearToLog(estimateMagnitude(sample.ch1));
                levelQ.push_back(lv);
                levelDue.push_back(cycle + 4);
            end
            // Writes land after this edge's read and loop update
            if (regWr) begin
                case (regAddr)
                    `AGC_REG_CTRL: begin
                        mirror.bypass = regWrData[0];
                        mirror.freeze = regWrData[1];
                    end
                    `AGC_REG_SETPOINT: mirror.setpoint  = regWrData[`AGC_LOG_WIDTH-1:0];
                    `AGC_REG_SHIFT:    mirror.loopShift = regWrData[3:0];
                    default: ;
                endcase
            end
        end
        pending = levelQ.size() + gainQ.size() + int'(rdPending);
    end

endmodule

//--- rtl/channelAgc.sv
/*
 * Two-channel receiver AGC
 * Level detection per channel feeding a shared gain loop
 */
`include "agc_config.svh"

module channelAgc (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sampleValid,
    input  agcPkg::DualIq              sample,
    input  logic                       regWr,
    input  logic                       regRd,
    input  logic [`AGC_ADDR_WIDTH-1:0] regAddr,
    input  logic [31:0]                regWrData,
    output logic [31:0]                regRdData,
    output logic                       gainValid,
    output agcPkg::GainPair            gains
);

    logic                        levelValid0;
    logic                        levelValid1;
    logic [`AGC_LEVEL_WIDTH-1:0] linLevel0;
    logic [`AGC_LEVEL_WIDTH-1:0] linLevel1;
    logic                        logValid0;
    agcPkg::LevelPair            logLevels;
    agcPkg::AgcCtrl              ctrl;

    // Channel 0 level path, 2 + 2 cycles
    magEstimator u_mag0 (
        .clk(clk), .rst(rst), .inValid(sampleValid), .sample(sample.ch0),
        .levelValid(levelValid0), .level(linLevel0)
    );
    log2Converter u_log0 (
        .clk(clk), .rst(rst), .inValid(levelValid0), .linear(linLevel0),
        .logValid(logValid0), .logLevel(logLevels.level0)
    );

    // Channel 1 level path
    magEstimator u_mag1 (
        .clk(clk), .rst(rst), .inValid(sampleValid), .sample(sample.ch1),
        .levelValid(levelValid1), .level(linLevel1)
    );
    // Runs in lockstep with channel 0, so its valid is not needed
    log2Converter u_log1 (
        .clk(clk), .rst(rst), .inValid(levelValid1), .linear(linLevel1),
        .logValid(), .logLevel(logLevels.level1)
    );

    // Control and status
    agcRegs u_regs (
        .clk(clk), .rst(rst), .regWr(regWr), .regRd(regRd), .regAddr(regAddr),
        .regWrData(regWrData), .levels(logLevels), .gains(gains),
        .regRdData(regRdData), .ctrl(ctrl)
    );

    // Shared loop, one more cycle
    agcLoopFilter u_loop (
        .clk(clk), .rst(rst), .inValid(logValid0), .levels(logLevels), .ctrl(ctrl),
        .gainValid(gainValid), .gains(gains)
    );

endmodule

//--- rtl/agcRegs.sv
/*
 * AGC register bank
 * Loop control registers plus registered readback of levels and gains
 */
`include "agc_config.svh"

module agcRegs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       regWr,
    input  logic                       regRd,
    input  logic [`AGC_ADDR_WIDTH-1:0] regAddr,
    input  logic [31:0]                regWrData,
    input  agcPkg::LevelPair           levels,
    input  agcPkg::GainPair            gains,
    output logic [31:0]                regRdData,
    output agcPkg::AgcCtrl             ctrl
);

    logic [31:0] rdMux;

    // Writes, read-only and unused addresses fall through
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.bypass    <= 1'b0;
            ctrl.freeze    <= 1'b0;
            ctrl.setpoint  <= `AGC_SETPOINT_RESET;
            ctrl.loopShift <= `AGC_SHIFT_RESET;
        end else if (regWr) begin
            case (regAddr)
                `AGC_REG_CTRL: begin
                    ctrl.bypass <= regWrData[0];
                    ctrl.freeze <= regWrData[1];
                end
                `AGC_REG_SETPOINT: ctrl.setpoint  <= regWrData[`AGC_LOG_WIDTH-1:0];
                `AGC_REG_SHIFT:    ctrl.loopShift <= regWrData[3:0];
                default: ;
            endcase
        end
    end

    // Read select, zero for anything unmapped
    always_comb begin
        case (regAddr)
            `AGC_REG_CTRL:     rdMux = {30'd0, ctrl.freeze, ctrl.bypass};
            `AGC_REG_SETPOINT: rdMux = 32'(ctrl.setpoint);
            `AGC_REG_SHIFT:    rdMux = 32'(ctrl.loopShift);
            `AGC_REG_LEVEL0:   rdMux = 32'(levels.level0);
            `AGC_REG_LEVEL1:   rdMux = 32'(levels.level1);
            `AGC_REG_GAIN0:    rdMux = 32'(gains.gain0);
            `AGC_REG_GAIN1:    rdMux = 32'(gains.gain1);
            default:           rdMux = 32'd0;
        endcase
    end

    // Read data appears the cycle after the strobe and holds
    always_ff @(posedge clk) begin
        if (rst) begin
            regRdData <= 32'd0;
        end else if (regRd) begin
            regRdData <= rdMux;
        end
    end

endmodule

//--- rtl/agcLoopFilter.sv
/*
 * Dual-channel AGC loop filter
 * Integrates setpoint minus log level into clamped per-channel gains
 */
`include "agc_config.svh"

module agcLoopFilter (
    input  logic             clk,
    input  logic             rst,
    input  logic             inValid,
    input  agcPkg::LevelPair levels,
    input  agcPkg::AgcCtrl   ctrl,
    output logic             gainValid,
    output agcPkg::GainPair  gains
);

    localparam int AccWidth = `AGC_ACC_WIDTH;
    localparam int SumWidth = `AGC_ACC_WIDTH + 2;
    localparam int ErrWidth = `AGC_LOG_WIDTH + 1;
    localparam logic [AccWidth-1:0] AccMax = {1'b0, {(AccWidth - 1){1'b1}}};
    // Gain seen at the accumulator reset point
    localparam logic [`AGC_GAIN_WIDTH-1:0] InitGain =
        `AGC_GAIN_WIDTH'(`AGC_INIT_ACC >> (AccWidth - `AGC_GAIN_WIDTH));

    logic [AccWidth-1:0] acc0;
    logic [AccWidth-1:0] acc1;
    logic [AccWidth-1:0] nextAcc0;
    logic [AccWidth-1:0] nextAcc1;
    logic                holdAcc;

    // One integrator step with clamping to 0 .. 2^31-1
    function automatic logic [AccWidth-1:0] stepAcc(
        input logic [AccWidth-1:0]       acc,
        input logic [`AGC_LOG_WIDTH-1:0] level,
        input logic [`AGC_LOG_WIDTH-1:0] setpoint,
        input logic [3:0]                shift
    );
        logic signed [ErrWidth-1:0] err;
        logic signed [SumWidth-1:0] sum;
        err = $signed({1'b0, setpoint}) - $signed({1'b0, level});
        // Sign extended error scaled by the loop shift
        sum = $signed({2'b00, acc}) + (SumWidth'(err) <<< shift);
        if (sum < 0) begin
            return '0;
        end else if (sum > $signed({2'b00, AccMax})) begin
            return AccMax;
        end
        return sum[AccWidth-1:0];
    endfunction

    // Freeze and bypass both stop integration
    assign holdAcc = ctrl.freeze | ctrl.bypass;

    always_comb begin
        if (holdAcc) begin
            nextAcc0 = acc0;
            nextAcc1 = acc1;
        end else begin
            nextAcc0 = stepAcc(acc0, levels.level0, ctrl.setpoint, ctrl.loopShift);
            nextAcc1 = stepAcc(acc1, levels.level1, ctrl.setpoint, ctrl.loopShift);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc0      <= `AGC_INIT_ACC;
            acc1      <= `AGC_INIT_ACC;
            gainValid <= 1'b0;
            // Gains start at the accumulator reset point
            gains.gain0 <= InitGain;
            gains.gain1 <= InitGain;
        end else begin
            gainValid <= inValid;
            if (inValid) begin
                acc0 <= nextAcc0;
                acc1 <= nextAcc1;
                // Bypass forces unity while the accumulators keep their value
                if (ctrl.bypass) begin
                    gains.gain0 <= `AGC_UNITY_GAIN;
                    gains.gain1 <= `AGC_UNITY_GAIN;
                end else begin
                    gains.gain0 <= nextAcc0[AccWidth-1 -: `AGC_GAIN_WIDTH];
                    gains.gain1 <= nextAcc1[AccWidth-1 -: `AGC_GAIN_WIDTH];
                end
            end
        end
    end

endmodule

//--- rtl/log2Converter.sv
/*
 * Linear to log2 converter
 * Leading-one position as integer part, next 8 bits as fraction
 */
`include "agc_config.svh"

module log2Converter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inValid,
    input  logic [`AGC_LEVEL_WIDTH-1:0] linear,
    output logic                        logValid,
    output logic [`AGC_LOG_WIDTH-1:0]   logLevel
);

    localparam int FracWidth = 8;
    localparam int ExtWidth  = `AGC_LEVEL_WIDTH + FracWidth;

    logic [3:0]                  leadPos;
    logic [3:0]                  posReg;
    logic [`AGC_LEVEL_WIDTH-1:0] linReg;
    logic                        stageValid;
    logic [ExtWidth-1:0]         extended;
    logic [ExtWidth-1:0]         normalized;

    // Priority encoder, highest set bit wins
    // Zero input leaves the position at 0
    always_comb begin
        leadPos = 4'd0;
        for (int b = 0; b < `AGC_LEVEL_WIDTH; b++) begin
            if (linear[b]) begin
                leadPos = 4'(b);
            end
        end
    end

    // Pad with zeros below bit 0 so small inputs still fill the fraction
    assign extended   = {linReg, {FracWidth{1'b0}}};
    // Bits just below the leading one land in the low byte
    assign normalized = extended >> posReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
            logValid   <= 1'b0;
        end else begin
            stageValid <= inValid;
            logValid   <= stageValid;
        end
    end

    // Stage 1 holds position and input, stage 2 packs 4.8 result
    always_ff @(posedge clk) begin
        if (inValid) begin
            posReg <= leadPos;
            linReg <= linear;
        end
        if (stageValid) begin
            // A zero input gives position 0 and an empty fraction
            logLevel <= {posReg, normalized[FracWidth-1:0]};
        end
    end

endmodule

//--- rtl/magEstimator.sv
/*
 * Magnitude estimator
 * alpha*max + beta*min approximation of |I + jQ|, two pipeline stages
 */
`include "agc_config.svh"

module magEstimator (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inValid,
    input  agcPkg::IqSample             sample,
    output logic                        levelValid,
    output logic [`AGC_LEVEL_WIDTH-1:0] level
);

    localparam int MagWidth  = `AGC_SAMPLE_WIDTH - 1;
    localparam int ProdWidth = 2 * MagWidth;

    logic [`AGC_SAMPLE_WIDTH-1:0] absI;
    logic [`AGC_SAMPLE_WIDTH-1:0] absQ;
    logic [MagWidth-1:0]          satI;
    logic [MagWidth-1:0]          satQ;
    logic [MagWidth-1:0]          maxMag;
    logic [MagWidth-1:0]          minMag;
    logic                         magValid;
    logic [ProdWidth-1:0]         maxProd;
    logic [ProdWidth-1:0]         minProd;
    logic [MagWidth:0]            levelSum;

    // Absolute values, -2^17 comes out as 2^17 unsigned
    assign absI = sample.i[`AGC_SAMPLE_WIDTH-1] ? `AGC_SAMPLE_WIDTH'(-sample.i) : sample.i;
    assign absQ = sample.q[`AGC_SAMPLE_WIDTH-1] ? `AGC_SAMPLE_WIDTH'(-sample.q) : sample.q;

    // Clip the single overflow case to full scale
    assign satI = absI[MagWidth] ? {MagWidth{1'b1}} : absI[MagWidth-1:0];
    assign satQ = absQ[MagWidth] ? {MagWidth{1'b1}} : absQ[MagWidth-1:0];

    // Weighted terms, each scaled back down by 2^17
    assign maxProd  = ProdWidth'(maxMag) * ProdWidth'(`AGC_ALPHA);
    assign minProd  = ProdWidth'(minMag) * ProdWidth'(`AGC_BETA);
    assign levelSum = (MagWidth + 1)'(maxProd >> 17) + (MagWidth + 1)'(minProd >> 17);

    // Valid pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            magValid   <= 1'b0;
            levelValid <= 1'b0;
        end else begin
            magValid   <= inValid;
            levelValid <= magValid;
        end
    end

    // Stage 1 orders the magnitudes, stage 2 sums and saturates
    always_ff @(posedge clk) begin
        if (inValid) begin
            maxMag <= (satI > satQ) ? satI : satQ;
            minMag <= (satI > satQ) ? satQ : satI;
        end
        if (magValid) begin
            level <= (levelSum > (MagWidth + 1)'(16'hFFFF)) ? 16'hFFFF
                                                             : levelSum[`AGC_LEVEL_WIDTH-1:0];
        end
    end

endmodule

//--- rtl/agcPkg.sv
/*
 * AGC shared types
 * Packed structs for samples, level and gain pairs and loop control
 */
`include "agc_config.svh"

package agcPkg;

    // One complex sample
    typedef struct packed {
        logic signed [`AGC_SAMPLE_WIDTH-1:0] i;
        logic signed [`AGC_SAMPLE_WIDTH-1:0] q;
    } IqSample;

    // Both receiver channels, sampled together
    typedef struct packed {
        IqSample ch0;
        IqSample ch1;
    } DualIq;

    // Log2 levels, 4.8 format
    typedef struct packed {
        logic [`AGC_LOG_WIDTH-1:0] level0;
        logic [`AGC_LOG_WIDTH-1:0] level1;
    } LevelPair;

    // Loop gains, upper accumulator bits
    typedef struct packed {
        logic [`AGC_GAIN_WIDTH-1:0] gain0;
        logic [`AGC_GAIN_WIDTH-1:0] gain1;
    } GainPair;

    // Software loop control
    typedef struct packed {
        logic                      bypass;
        logic                      freeze;
        logic [`AGC_LOG_WIDTH-1:0] setpoint;
        logic [3:0]                loopShift;
    } AgcCtrl;

endpackage

//--- rtl/agc_config.svh
/*
 * AGC configuration
 * Widths, estimator weights, reset values and the register map
 */
`ifndef AGC_CONFIG_SVH
`define AGC_CONFIG_SVH

// Datapath widths
`define AGC_SAMPLE_WIDTH    18
`define AGC_LEVEL_WIDTH     16
`define AGC_LOG_WIDTH       12
`define AGC_ACC_WIDTH       32
`define AGC_GAIN_WIDTH      21

// Min peak error weights, scaled by 2^17
`define AGC_ALPHA           125886
`define AGC_BETA            52144

// Loop start point and bypass gain, both a gain of 2^20
`define AGC_INIT_ACC        32'h8000_0000
`define AGC_UNITY_GAIN      21'h10_0000

// Register map
`define AGC_ADDR_WIDTH      4
`define AGC_REG_CTRL        4'd0
`define AGC_REG_SETPOINT    4'd1
`define AGC_REG_SHIFT       4'd2
`define AGC_REG_LEVEL0      4'd3
`define AGC_REG_LEVEL1      4'd4
`define AGC_REG_GAIN0       4'd5
`define AGC_REG_GAIN1       4'd6

// Register reset values
`define AGC_SETPOINT_RESET  12'hA00
`define AGC_SHIFT_RESET     4'd4

`endif
